/* cnnCfgPkg.sv */
`default_nettype none

package cnnCfgPkg;

    // ==================================================
    // Loop configuration widths
    // ==================================================

    // Activations per row minus one
    localparam int LenRowW = 4;

    // Rows per block minus one, and blocks minus one
    localparam int BlkW = 4;

    // Patch repetitions minus one
    localparam int PatW = 3;

    // ==================================================
    // Fetch controller states
    // ==================================================

    // IDLE waits for start
    // RUN issues one read per pending request
    // DRAIN waits for the last word to leave the pipe
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } fetchState_e;

    // Widest single loop count, for sizing helpers
    localparam int MaxLoopW = (LenRowW > BlkW) ? LenRowW : BlkW;

    // Outer patch loop stays narrower than the inner ones
    localparam int LoopWSum = LenRowW + 2 * BlkW + PatW;

endpackage

`default_nettype wire

/* actBufPkg.sv */
`default_nettype none

package actBufPkg;

    // ==================================================
    // Activation buffer geometry
    // ==================================================

    // Word address width
    localparam int AddrW = 8;

    // Activation word width
    localparam int DataW = 16;

    // Number of words held in the buffer
    localparam int BufDepth = 256;

    // ==================================================
    // Arbiter ownership
    // ==================================================

    // Who drives the buffer port this cycle
    typedef enum logic [1:0] {
        NONE,
        LOAD,
        FETCH
    } arbClient_e;

endpackage

`default_nettype wire

/* actBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module actBuffer #(
    parameter int AddrW = actBufPkg::AddrW,
    parameter int DataW = actBufPkg::DataW
) (
    input  logic             clk,
    input  logic             memEn,
    input  logic             memWe,
    input  logic [AddrW-1:0] memAddr,
    input  logic [DataW-1:0] memWdata,
    output logic [DataW-1:0] memRdata
);

    import actBufPkg::*;

    // ==================================================
    // Storage
    // ==================================================

    // Word array, no reset on contents
    logic [DataW-1:0] mem [BufDepth];

    // Write port
    always_ff @(posedge clk) begin
        if (memEn && memWe) begin
            mem[memAddr] <= memWdata;
        end
    end

    // Registered read, data shows up one cycle after the access
    // Output holds its value on idle cycles
    always_ff @(posedge clk) begin
        if (memEn && !memWe) begin
            memRdata <= mem[memAddr];
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Any access must land inside the physical array
    memAddrRange: assert property (@(posedge clk)
        memEn |-> (int'(memAddr) < BufDepth))
        else $error("actBuffer: address %0d out of range", memAddr);

endmodule

`default_nettype wire

/* actBufArb.sv */
`timescale 1ns/1ps
`default_nettype none

module actBufArb #(
    parameter int AddrW = actBufPkg::AddrW,
    parameter int DataW = actBufPkg::DataW
) (
    input  logic             clk,
    input  logic             rst_n,
    // Loader side
    input  logic             ldReq,
    input  logic [AddrW-1:0] ldAddr,
    input  logic [DataW-1:0] ldData,
    // Fetch side
    input  logic             feReq,
    input  logic [AddrW-1:0] feAddr,
    output logic             feGnt,
    // Buffer port
    output logic             memEn,
    output logic             memWe,
    output logic [AddrW-1:0] memAddr,
    output logic [DataW-1:0] memWdata
);

    import actBufPkg::*;

    // Current owner of the port
    arbClient_e owner;

    // Consecutive cycles the fetch side asked and lost
    logic [6:0] denyCnt;

    // ==================================================
    // Fixed priority select
    // ==================================================

    // Loader first, so no write is ever dropped
    always_comb begin
        if (ldReq) begin
            owner = LOAD;
        end else if (feReq) begin
            owner = FETCH;
        end else begin
            owner = NONE;
        end
    end

    assign feGnt    = (owner == FETCH);
    assign memEn    = (owner != NONE);
    assign memWe    = (owner == LOAD);
    // Address mux follows the owner
    assign memAddr  = (owner == LOAD) ? ldAddr : feAddr;
    // Only the loader writes
    assign memWdata = ldData;

    // Starvation counter, clears on any cycle without a denied request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            denyCnt <= '0;
        end else if (feReq && !feGnt) begin
            denyCnt <= (denyCnt == '1) ? denyCnt : denyCnt + 1'b1;
        end else begin
            denyCnt <= '0;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Loader traffic must leave the fetch side a slot now and then
    fetchNotStarved: assert property (@(posedge clk) disable iff (!rst_n)
        denyCnt < 7'd64)
        else $error("actBufArb: fetch denied for %0d cycles", denyCnt);

    // A read grant never turns into a write on the buffer
    fetchIsRead: assert property (@(posedge clk) disable iff (!rst_n)
        feGnt |-> (memEn && !memWe))
        else $error("actBufArb: write strobe during fetch grant");

endmodule

`default_nettype wire

/* actLoader.sv */
`timescale 1ns/1ps
`default_nettype none

module actLoader #(
    parameter int AddrW = actBufPkg::AddrW,
    parameter int DataW = actBufPkg::DataW
) (
    input  logic             clk,
    input  logic             rst_n,
    // External write strobe
    input  logic             wrEn,
    input  logic [AddrW-1:0] wrAddr,
    input  logic [DataW-1:0] wrData,
    // Request toward the arbiter
    output logic             ldReq,
    output logic [AddrW-1:0] ldAddr,
    output logic [DataW-1:0] ldData
);

    import actBufPkg::*;

    // ==================================================
    // Write stage
    // ==================================================

    // Request follows the strobe by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ldReq <= 1'b0;
        end else begin
            ldReq <= wrEn;
        end
    end

    // Address and data are captured only on a strobe
    always_ff @(posedge clk) begin
        if (wrEn) begin
            ldAddr <= wrAddr;
            ldData <= wrData;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Strobe must target a real word
    wrAddrRange: assert property (@(posedge clk) disable iff (!rst_n)
        wrEn |-> (int'(wrAddr) < BufDepth))
        else $error("actLoader: write to address %0d beyond buffer", wrAddr);

endmodule

`default_nettype wire

/* actFetchCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module actFetchCtrl #(
    parameter int AddrW = actBufPkg::AddrW,
    parameter int DataW = actBufPkg::DataW
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           getAct,
    // Loop configuration, each value is count minus one
    input  logic [cnnCfgPkg::LenRowW-1:0] cfgLenRow,
    input  logic [cnnCfgPkg::BlkW-1:0]    cfgDepBlk,
    input  logic [cnnCfgPkg::BlkW-1:0]    cfgNumBlk,
    input  logic [cnnCfgPkg::PatW-1:0]    cfgNumPat,
    // Buffer request
    output logic                           feReq,
    output logic [AddrW-1:0]               feAddr,
    input  logic                           feGnt,
    input  logic [DataW-1:0]               memRdata,
    // Activation stream
    output logic                           actValid,
    output logic [DataW-1:0]               actData,
    output logic                           frtActRow,
    output logic                           lstActRow,
    output logic                           lstActBlk,
    output logic                           done
);

    import cnnCfgPkg::*;

    // Room for long denial stretches from the loader
    localparam int PendW = 8;

    fetchState_e state;

    // Latched configuration
    logic [LenRowW-1:0] lenRow;
    logic [BlkW-1:0]    depBlk;
    logic [BlkW-1:0]    numBlk;
    logic [PatW-1:0]    numPat;

    // Loop counters, innermost first
    logic [LenRowW-1:0] cntAct;
    logic [BlkW-1:0]    cntRow;
    logic [BlkW-1:0]    cntBlk;
    logic [PatW-1:0]    cntPat;

    logic [AddrW-1:0]   runAddr;
    logic [PendW-1:0]   pendCnt;

    // Wrap conditions
    logic lastAct, lastRow, lastBlk, lastPat;
    logic lastInPatch, lastAll;
    logic pendInc;

    // ==================================================
    // Loop control
    // ==================================================

    assign lastAct     = (cntAct == lenRow);
    assign lastRow     = (cntRow == depBlk);
    assign lastBlk     = (cntBlk == numBlk);
    assign lastPat     = (cntPat == numPat);
    assign lastInPatch = lastAct && lastRow && lastBlk;
    assign lastAll     = lastInPatch && lastPat;

    // Requests only count while reading
    assign pendInc = getAct && (state == RUN);

    assign feReq  = (state == RUN) && (pendCnt != '0);
    // Loop order makes the address rule a plain running count per patch
    assign feAddr = runAddr;

    // Config captured once per run
    always_ff @(posedge clk) begin
        if (start && (state == IDLE)) begin
            lenRow <= cfgLenRow;
            depBlk <= cfgDepBlk;
            numBlk <= cfgNumBlk;
            numPat <= cfgNumPat;
        end
    end

    // State, counters and address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            cntAct  <= '0;
            cntRow  <= '0;
            cntBlk  <= '0;
            cntPat  <= '0;
            runAddr <= '0;
            pendCnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= RUN;
                        cntAct  <= '0;
                        cntRow  <= '0;
                        cntBlk  <= '0;
                        cntPat  <= '0;
                        runAddr <= '0;
                        pendCnt <= '0;
                    end
                end
                RUN: begin
                    // Net pending change this cycle
                    if (pendInc && !feGnt) begin
                        pendCnt <= pendCnt + 1'b1;
                    end else if (!pendInc && feGnt) begin
                        pendCnt <= pendCnt - 1'b1;
                    end
                    if (feGnt) begin
                        // Each counter wraps and carries outward
                        cntAct <= lastAct ? '0 : cntAct + 1'b1;
                        if (lastAct) begin
                            cntRow <= lastRow ? '0 : cntRow + 1'b1;
                        end
                        if (lastAct && lastRow) begin
                            cntBlk <= lastBlk ? '0 : cntBlk + 1'b1;
                        end
                        if (lastInPatch) begin
                            cntPat <= lastPat ? '0 : cntPat + 1'b1;
                        end
                        // New patch restarts at word 0
                        runAddr <= lastInPatch ? '0 : runAddr + 1'b1;
                        if (lastAll) begin
                            state   <= DRAIN;
                            pendCnt <= '0;
                        end
                    end
                end
                DRAIN: begin
                    // Final word is on the output now
                    if (actValid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ==================================================
    // Flag pipeline and completion
    // ==================================================

    // Flags of the granted address line up with the returned word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            actValid  <= 1'b0;
            frtActRow <= 1'b0;
            lstActRow <= 1'b0;
            lstActBlk <= 1'b0;
            done      <= 1'b0;
        end else begin
            actValid  <= feGnt;
            frtActRow <= feGnt && (cntAct == '0);
            lstActRow <= feGnt && lastAct;
            lstActBlk <= feGnt && lastAct && lastRow;
            done      <= (state == DRAIN) && actValid;
        end
    end

    // Buffer output is already one cycle behind the grant
    assign actData = memRdata;

    // No request and no grant outside an active run
    idleQuiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> (!feReq && !feGnt))
        else $error("actFetchCtrl: buffer request while idle");

    // Pending count must not wrap when requests outrun grants
    pendNoWrap: assert property (@(posedge clk) disable iff (!rst_n)
        (pendInc && !feGnt) |-> (pendCnt != '1))
        else $error("actFetchCtrl: pending request count overflow");

endmodule

`default_nettype wire

/* cnnActTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cnnActTop #(
    parameter int AddrW = actBufPkg::AddrW,
    parameter int DataW = actBufPkg::DataW
) (
    input  logic                           clk,
    input  logic                           rst_n,
    // External write strobe
    input  logic                           wrEn,
    input  logic [AddrW-1:0]               wrAddr,
    input  logic [DataW-1:0]               wrData,
    // Fetch control
    input  logic                           start,
    input  logic                           getAct,
    input  logic [cnnCfgPkg::LenRowW-1:0] cfgLenRow,
    input  logic [cnnCfgPkg::BlkW-1:0]    cfgDepBlk,
    input  logic [cnnCfgPkg::BlkW-1:0]    cfgNumBlk,
    input  logic [cnnCfgPkg::PatW-1:0]    cfgNumPat,
    // Activation stream
    output logic                           actValid,
    output logic [DataW-1:0]               actData,
    output logic                           frtActRow,
    output logic                           lstActRow,
    output logic                           lstActBlk,
    output logic                           done
);

    // Loader to arbiter
    logic             ldReq;
    logic [AddrW-1:0] ldAddr;
    logic [DataW-1:0] ldData;
    // Fetch to arbiter
    logic             feReq;
    logic [AddrW-1:0] feAddr;
    logic             feGnt;
    // Arbiter to buffer
    logic             memEn;
    logic             memWe;
    logic [AddrW-1:0] memAddr;
    logic [DataW-1:0] memWdata;
    logic [DataW-1:0] memRdata;

    actLoader #(.AddrW(AddrW), .DataW(DataW)) i_loader (
        .clk(clk), .rst_n(rst_n),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .ldReq(ldReq), .ldAddr(ldAddr), .ldData(ldData)
    );

    actBufArb #(.AddrW(AddrW), .DataW(DataW)) i_arb (
        .clk(clk), .rst_n(rst_n),
        .ldReq(ldReq), .ldAddr(ldAddr), .ldData(ldData),
        .feReq(feReq), .feAddr(feAddr), .feGnt(feGnt),
        .memEn(memEn), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
    );

    actBuffer #(.AddrW(AddrW), .DataW(DataW)) i_buf (
        .clk(clk), .memEn(memEn), .memWe(memWe),
        .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata)
    );

    actFetchCtrl #(.AddrW(AddrW), .DataW(DataW)) i_fetch (
        .clk(clk), .rst_n(rst_n), .start(start), .getAct(getAct),
        .cfgLenRow(cfgLenRow), .cfgDepBlk(cfgDepBlk),
        .cfgNumBlk(cfgNumBlk), .cfgNumPat(cfgNumPat),
        .feReq(feReq), .feAddr(feAddr), .feGnt(feGnt), .memRdata(memRdata),
        .actValid(actValid), .actData(actData), .frtActRow(frtActRow),
        .lstActRow(lstActRow), .lstActBlk(lstActBlk), .done(done)
    );

endmodule

`default_nettype wire

/* tbActChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module tbActChecker #(
    parameter int DataW = actBufPkg::DataW
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             actValid,
    input  logic [DataW-1:0] actData,
    input  logic             frtActRow,
    input  logic             lstActRow,
    input  logic             lstActBlk,
    input  logic             done
);

    // Expected entry, flags {frt, lst, blk} above the word
    logic [DataW+2:0] expQ [$];

    // Error and event counters, read by the testbench top
    int dataErrs = 0;
    int flagErrs = 0;
    int ctlErrs  = 0;
    int valCnt   = 0;
    int doneCnt  = 0;

    // Set once the last queued word went by
    logic doneDue = 1'b0;

    // Queue one expected activation
    task automatic expectWord(input logic [DataW-1:0] word, input logic frt,
                              input logic lst, input logic blk);
        expQ.push_back({frt, lst, blk, word});
    endtask

    // Words still owed by the DUT
    function automatic int leftCount();
        return expQ.size();
    endfunction

    // ==================================================
    // Compare on every rising edge
    // ==================================================
    always @(posedge clk) begin
        logic [DataW+2:0] expEntry;
        if (rst_n) begin
            // Done must follow the final word by one cycle
            if (doneDue) begin
                if (done) begin
                    doneCnt++;
                end else begin
                    ctlErrs++;
                    $display("Missing done pulse at %0t after the final word", $time);
                end
                doneDue = 1'b0;
            end else if (done) begin
                doneCnt++;
                ctlErrs++;
                $display("Unexpected done pulse at %0t", $time);
            end
            if (actValid) begin
                valCnt++;
                if (expQ.size() == 0) begin
                    ctlErrs++;
                    $display("Unexpected actValid at %0t with no word expected", $time);
                end else begin
                    expEntry = expQ.pop_front();
                    if (actData !== expEntry[DataW-1:0]) begin
                        dataErrs++;
                        $display("ERR %0t: word %0d data 0x%h, expected 0x%h", $time,
                                 valCnt, actData, expEntry[DataW-1:0]);
                    end
                    if ({frtActRow, lstActRow, lstActBlk} !== expEntry[DataW+2:DataW]) begin
                        flagErrs++;
                        $display("ERR %0t: word %0d flags %b, expected %b", $time, valCnt,
                                 {frtActRow, lstActRow, lstActBlk}, expEntry[DataW+2:DataW]);
                    end
                    // Queue only empties on the last word of a run
                    if (expQ.size() == 0) begin
                        doneDue = 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_cnnActTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cnnActTop;

    import actBufPkg::*;
    import cnnCfgPkg::*;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               wrEn;
    logic [AddrW-1:0]   wrAddr;
    logic [DataW-1:0]   wrData;
    logic               start;
    logic               getAct;
    logic [LenRowW-1:0] cfgLenRow;
    logic [BlkW-1:0]    cfgDepBlk;
    logic [BlkW-1:0]    cfgNumBlk;
    logic [PatW-1:0]    cfgNumPat;
    logic               actValid;
    logic [DataW-1:0]   actData;
    logic               frtActRow;
    logic               lstActRow;
    logic               lstActBlk;
    logic               done;

    // Mirror of the buffer contents
    logic [DataW-1:0] model [BufDepth];

    logic [31:0] rngState = 32'h6937935c;

    // Shape per run in order single pass, patches, contention, reconfig
    int cfgL [4];
    int cfgD [4];
    int cfgB [4];
    int cfgP [4];

    int wdCycles  = 0;
    int testsPass = 0;
    int testsFail = 0;

    always #2 clk = ~clk;

    cnnActTop #(.AddrW(AddrW), .DataW(DataW)) i_dut (
        .clk(clk), .rst_n(rst_n),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .start(start), .getAct(getAct),
        .cfgLenRow(cfgLenRow), .cfgDepBlk(cfgDepBlk),
        .cfgNumBlk(cfgNumBlk), .cfgNumPat(cfgNumPat),
        .actValid(actValid), .actData(actData), .frtActRow(frtActRow),
        .lstActRow(lstActRow), .lstActBlk(lstActBlk), .done(done)
    );

    tbActChecker #(.DataW(DataW)) i_chk (
        .clk(clk), .rst_n(rst_n), .actValid(actValid), .actData(actData),
        .frtActRow(frtActRow), .lstActRow(lstActRow), .lstActBlk(lstActBlk),
        .done(done)
    );

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // Words in one patch
    function automatic int patchWords(input int l, input int d, input int b);
        return (l + 1) * (d + 1) * (b + 1);
    endfunction

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            wrEn   = 1'b0;
            getAct = 1'b0;
        end
    endtask

    // Write strobe in the current cycle and the model follows at once
    task automatic driveWrite(input int addr, input logic [DataW-1:0] data);
        wrEn   = 1'b1;
        wrAddr = AddrW'(addr);
        wrData = data;
        model[addr] = data;
    endtask

    // Write strobe on the next falling edge
    task automatic writeWord(input int addr, input logic [DataW-1:0] data);
        @(negedge clk);
        driveWrite(addr, data);
    endtask

    // Expected stream straight from the loop and address rule
    task automatic planRun(input int l, input int d, input int b, input int p,
                           output int words);
        int addr;
        words = 0;
        for (int pi = 0; pi <= p; pi++) begin
            for (int bi = 0; bi <= b; bi++) begin
                for (int ri = 0; ri <= d; ri++) begin
                    for (int ai = 0; ai <= l; ai++) begin
                        addr = bi * (d + 1) * (l + 1) + ri * (l + 1) + ai;
                        i_chk.expectWord(model[addr], ai == 0, ai == l,
                                         (ri == d) && (ai == l));
                        words++;
                    end
                end
            end
        end
    endtask

    task automatic startRun(input int l, input int d, input int b, input int p);
        @(negedge clk);
        start     = 1'b1;
        cfgLenRow = LenRowW'(l);
        cfgDepBlk = BlkW'(d);
        cfgNumBlk = BlkW'(b);
        cfgNumPat = PatW'(p);
        @(negedge clk);
        start = 1'b0;
    endtask

    // Issue n request pulses
    // Gapped mode adds idle cycles and loader writes from wrLow up
    task automatic issueGets(input int n, input bit gapped, input int wrLow);
        int sent;
        logic [31:0] r;
        logic [31:0] w;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            r      = nextRand();
            getAct = !gapped || (r[1:0] == 2'd0);
            wrEn   = 1'b0;
            if (gapped && (r[4:3] == 2'd0)) begin
                w = nextRand();
                driveWrite(wrLow + int'(w[23:16]) % (BufDepth - wrLow), w[DataW-1:0]);
            end
            if (getAct) begin
                sent++;
            end
        end
        idleCycles(1);
    endtask

    // Bounded wait for done, sampled mid-cycle
    task automatic waitDone(input int limit, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && (n < limit)) begin
            @(negedge clk);
            seen = done;
            n++;
        end
        // Checker sees the done cycle on the next rising edge
        @(negedge clk);
    endtask

    task automatic runFetch(input int l, input int d, input int b, input int p,
                            input bit gapped, input int extra,
                            output bit streamOk, output bit flagOk);
        int words;
        int v0;
        int dn0;
        int e0;
        int f0;
        bit seen;
        v0  = i_chk.valCnt;
        dn0 = i_chk.doneCnt;
        e0  = i_chk.dataErrs + i_chk.ctlErrs;
        f0  = i_chk.flagErrs;
        planRun(l, d, b, p, words);
        startRun(l, d, b, p);
        issueGets(words, gapped, patchWords(l, d, b));
        waitDone(40 * words + 100, seen);
        if (!seen) begin
            $display("No done pulse within %0d cycles of the last request", 40 * words + 100);
        end
        // Requests after done must be ignored
        if (extra > 0) begin
            issueGets(extra, 1'b0, 0);
            idleCycles(10);
        end
        if (i_chk.valCnt - v0 != words) begin
            $display("Got %0d words for %0d requests", i_chk.valCnt - v0, words);
        end
        streamOk = seen && (i_chk.valCnt - v0 == words) && (i_chk.doneCnt - dn0 == 1)
                   && (i_chk.dataErrs + i_chk.ctlErrs == e0) && (i_chk.leftCount() == 0);
        flagOk = (i_chk.flagErrs == f0);
    endtask

    task automatic reportTest(input string name, input bit ok);
        if (ok) begin
            testsPass++;
        end else begin
            testsFail++;
        end
        $display("%s: %s", name, ok ? "pass" : "fail");
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        bit ok;
        bit flagOk;
        bit okR;
        bit flagR;
        bit quiet;
        int total;
        logic [31:0] r;
        rst_n     = 1'b0;
        wrEn      = 1'b0;
        wrAddr    = '0;
        wrData    = '0;
        start     = 1'b0;
        getAct    = 1'b0;
        cfgLenRow = '0;
        cfgDepBlk = '0;
        cfgNumBlk = '0;
        cfgNumPat = '0;
        // Shapes drawn up front so the watchdog knows the run length
        for (int i = 0; i < 4; i++) begin
            cfgL[i] = nextRand() % 8;
            cfgD[i] = nextRand() % 4;
            cfgB[i] = nextRand() % 4;
        end
        cfgP[0] = 0;
        cfgP[1] = 1 + nextRand() % 3;
        cfgP[2] = 0;
        cfgP[3] = nextRand() % 3;
        // Full readout plus the ignored extra requests
        total = BufDepth + 4;
        for (int i = 0; i < 4; i++) begin
            total += patchWords(cfgL[i], cfgD[i], cfgB[i]) * (cfgP[i] + 1);
        end
        wdCycles = 40 * total + 2000;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        quiet = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (actValid || done) begin
                quiet = 1'b0;
            end
        end
        reportTest("reset state", quiet && (i_chk.ctlErrs == 0));

        for (int a = 0; a < BufDepth; a++) begin
            r = nextRand();
            writeWord(a, r[DataW-1:0]);
        end
        idleCycles(4);

        runFetch(cfgL[0], cfgD[0], cfgB[0], cfgP[0], 1'b0, 0, ok, flagOk);
        reportTest("single pass readout", ok);
        reportTest("row and block flags", flagOk);

        runFetch(cfgL[1], cfgD[1], cfgB[1], cfgP[1], 1'b0, 4, ok, flagOk);
        reportTest("patch repetition and done", ok && flagOk);

        // Loader writes above the read window and a full readback after
        runFetch(cfgL[2], cfgD[2], cfgB[2], cfgP[2], 1'b1, 0, ok, flagOk);
        idleCycles(4);
        runFetch(15, 15, 0, 0, 1'b0, 0, okR, flagR);
        reportTest("contention", ok && flagOk && okR && flagR);

        runFetch(cfgL[3], cfgD[3], cfgB[3], cfgP[3], 1'b0, 0, ok, flagOk);
        reportTest("reconfiguration", ok && flagOk);

        $display("Tests passed %0d, failed %0d, checker errors %0d", testsPass, testsFail,
                 i_chk.dataErrs + i_chk.flagErrs + i_chk.ctlErrs);
        if ((testsFail == 0) && (i_chk.dataErrs + i_chk.flagErrs + i_chk.ctlErrs == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog limit is set once the run shapes are known
    initial begin
        wait (wdCycles > 0);
        repeat (wdCycles) @(posedge clk);
        $display("Timeout: run still busy after %0d cycles", wdCycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
cnnCfgPkg.sv
actBufPkg.sv
actBuffer.sv
actBufArb.sv
actLoader.sv
actFetchCtrl.sv
cnnActTop.sv
tbActChecker.sv
tb_cnnActTop.sv

/* Bender.yml */
package:
  name: cnn_act_fetch

sources:
  - cnnCfgPkg.sv
  - actBufPkg.sv
  - actBuffer.sv
  - actBufArb.sv
  - actLoader.sv
  - actFetchCtrl.sv
  - cnnActTop.sv
  - target: test
    files:
      - tbActChecker.sv
      - tb_cnnActTop.sv
